// File: hw/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input logic clk,
	input logic rstN,
	input logic validF,
	input mipsPkg::wordT instrF,
	input mipsPkg::wordT pcPlus4F,
	input logic predF,
	input logic excInstrF,
	input mipsPkg::jrTopT jrTopF,
	input logic stall,
	input logic flush,
	output logic validE,
	output mipsPkg::decodedOpT opE,
	output mipsPkg::controlT ctlE,
	output mipsPkg::cregAddrT srcRegAE,
	output mipsPkg::cregAddrT srcRegBE,
	output mipsPkg::cregAddrT destRegE,
	output mipsPkg::shamtT shamtE,
	output mipsPkg::cregAddrT cp0AddrE,
	output mipsPkg::wordT extImmE,
	output mipsPkg::wordT pcBranchE,
	output mipsPkg::wordT pcJumpE,
	output logic excReservedE,
	output logic excInstrE,
	output logic predE,
	output mipsPkg::wordT pcPlus4E,
	output mipsPkg::jrTopT jrTopE
);

	mipsPkg::fetchDataT fetchIn;
	mipsPkg::fetchDataT fetchD;
	mipsPkg::decodeDataT decodeD;
	mipsPkg::decodeDataT decodeE;
	logic validD;

	// loose fetch inputs into one bundle
	assign fetchIn = '{
		instr: instrF,
		pcPlus4: pcPlus4F,
		pred: predF,
		excInstr: excInstrF,
		jrTop: jrTopF
	};

	// F/D register holds while stalled
	pipeReg #(.payloadT(mipsPkg::fetchDataT)) fdReg (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.flush(flush),
		.bubble(1'b0),
		.validIn(validF),
		.dataIn(fetchIn),
		.validOut(validD),
		.dataOut(fetchD)
	);

	signalDecode signalDecode (
		.dataF(fetchD),
		.dataD(decodeD)
	);

	// D/E register never holds, a stall inserts a bubble
	pipeReg #(.payloadT(mipsPkg::decodeDataT)) deReg (
		.clk(clk),
		.rstN(rstN),
		.stall(1'b0),
		.flush(flush),
		.bubble(stall),
		.validIn(validD),
		.dataIn(decodeD),
		.validOut(validE),
		.dataOut(decodeE)
	);

	// registered bundle out on loose ports
	assign opE = decodeE.op;
	assign ctlE = decodeE.ctl;
	assign srcRegAE = decodeE.srcRegA;
	assign srcRegBE = decodeE.srcRegB;
	assign destRegE = decodeE.destReg;
	assign shamtE = decodeE.shamt;
	assign cp0AddrE = decodeE.cp0Addr;
	assign extImmE = decodeE.extImm;
	assign pcBranchE = decodeE.pcBranch;
	assign pcJumpE = decodeE.pcJump;
	assign excReservedE = decodeE.excReserved;
	assign excInstrE = decodeE.excInstr;
	assign predE = decodeE.pred;
	assign pcPlus4E = decodeE.pcPlus4;
	assign jrTopE = decodeE.jrTop;

endmodule

`default_nettype wire

// File: hw/mainDecode.sv
`timescale 1ns/1ps
`default_nettype none

module mainDecode (
	input mipsPkg::wordT instr,
	output mipsPkg::decodedOpT op,
	output mipsPkg::controlT ctl,
	output mipsPkg::cregAddrT srcRegA,
	output mipsPkg::cregAddrT srcRegB,
	output mipsPkg::cregAddrT destReg,
	output logic reserved
);

	// where the write destination comes from
	typedef enum logic [1:0] {
		DST_NONE,
		DST_RD,
		DST_RT,
		DST_RA
	} dstSelT;

	mipsPkg::opFieldT opField;
	mipsPkg::funcFieldT fn;
	mipsPkg::cregAddrT rs;
	mipsPkg::cregAddrT rt;
	mipsPkg::cregAddrT rd;
	dstSelT dstSel;

	// raw instruction fields
	assign opField = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign fn = instr[5:0];

	// step one: encoding to operation
	always_comb begin
		op = mipsPkg::RESERVED;
		case (opField)
			mipsPkg::OP_SPECIAL: begin
				case (fn)
					mipsPkg::FN_ADDU: op = mipsPkg::ADDU;
					mipsPkg::FN_SUBU: op = mipsPkg::SUBU;
					mipsPkg::FN_AND: op = mipsPkg::AND;
					mipsPkg::FN_OR: op = mipsPkg::OR;
					mipsPkg::FN_XOR: op = mipsPkg::XOR;
					mipsPkg::FN_NOR: op = mipsPkg::NOR;
					mipsPkg::FN_SLT: op = mipsPkg::SLT;
					mipsPkg::FN_SLTU: op = mipsPkg::SLTU;
					mipsPkg::FN_SLL: op = mipsPkg::SLL;
					mipsPkg::FN_SRL: op = mipsPkg::SRL;
					mipsPkg::FN_SRA: op = mipsPkg::SRA;
					mipsPkg::FN_JR: op = mipsPkg::JR;
					mipsPkg::FN_JALR: op = mipsPkg::JALR;
					mipsPkg::FN_MFHI: op = mipsPkg::MFHI;
					mipsPkg::FN_MFLO: op = mipsPkg::MFLO;
					mipsPkg::FN_MTHI: op = mipsPkg::MTHI;
					mipsPkg::FN_MTLO: op = mipsPkg::MTLO;
					mipsPkg::FN_MULT: op = mipsPkg::MULT;
					mipsPkg::FN_MULTU: op = mipsPkg::MULTU;
					mipsPkg::FN_DIV: op = mipsPkg::DIV;
					mipsPkg::FN_DIVU: op = mipsPkg::DIVU;
					mipsPkg::FN_SYSCALL: op = mipsPkg::SYSCALL;
					mipsPkg::FN_BREAK: op = mipsPkg::BREAK;
					default: op = mipsPkg::RESERVED;
				endcase
			end
			mipsPkg::OP_COP0: begin
				// sub-op lives in rs
				case (rs)
					mipsPkg::RS_MF: op = mipsPkg::MFC0;
					mipsPkg::RS_MT: op = mipsPkg::MTC0;
					mipsPkg::RS_CO: begin
						if (fn == mipsPkg::FN_ERET)
							op = mipsPkg::ERET;
					end
					default: op = mipsPkg::RESERVED;
				endcase
			end
			mipsPkg::OP_ADDIU: op = mipsPkg::ADDIU;
			mipsPkg::OP_SLTI: op = mipsPkg::SLTI;
			mipsPkg::OP_SLTIU: op = mipsPkg::SLTIU;
			mipsPkg::OP_ANDI: op = mipsPkg::ANDI;
			mipsPkg::OP_ORI: op = mipsPkg::ORI;
			mipsPkg::OP_XORI: op = mipsPkg::XORI;
			mipsPkg::OP_LUI: op = mipsPkg::LUI;
			mipsPkg::OP_LW: op = mipsPkg::LW;
			mipsPkg::OP_LB: op = mipsPkg::LB;
			mipsPkg::OP_LBU: op = mipsPkg::LBU;
			mipsPkg::OP_SW: op = mipsPkg::SW;
			mipsPkg::OP_SB: op = mipsPkg::SB;
			mipsPkg::OP_BEQ: op = mipsPkg::BEQ;
			mipsPkg::OP_BNE: op = mipsPkg::BNE;
			mipsPkg::OP_J: op = mipsPkg::J;
			mipsPkg::OP_JAL: op = mipsPkg::JAL;
			default: op = mipsPkg::RESERVED;
		endcase
	end

	// step two: operation to control bits and destination source
	always_comb begin
		ctl = '0;
		dstSel = DST_NONE;
		case (op)
			mipsPkg::ADDU, mipsPkg::SUBU, mipsPkg::AND, mipsPkg::OR,
			mipsPkg::XOR, mipsPkg::NOR, mipsPkg::SLT, mipsPkg::SLTU,
			mipsPkg::SLL, mipsPkg::SRL, mipsPkg::SRA,
			mipsPkg::MFHI, mipsPkg::MFLO: begin
				ctl.regWrite = 1'b1;
				dstSel = DST_RD;
			end
			mipsPkg::JR: begin
				ctl.jump = 1'b1;
				ctl.jumpReg = 1'b1;
			end
			mipsPkg::JALR: begin
				ctl.jump = 1'b1;
				ctl.jumpReg = 1'b1;
				ctl.link = 1'b1;
				ctl.regWrite = 1'b1;
				dstSel = DST_RD;
			end
			mipsPkg::ADDIU, mipsPkg::SLTI, mipsPkg::SLTIU: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				dstSel = DST_RT;
			end
			// logical immediates and lui take the zero-extended value
			mipsPkg::ANDI, mipsPkg::ORI, mipsPkg::XORI, mipsPkg::LUI: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.zeroExt = 1'b1;
				dstSel = DST_RT;
			end
			mipsPkg::LW, mipsPkg::LB, mipsPkg::LBU: begin
				ctl.regWrite = 1'b1;
				ctl.memRead = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.memByte = (op != mipsPkg::LW);
				ctl.memUnsigned = (op == mipsPkg::LBU);
				dstSel = DST_RT;
			end
			mipsPkg::SW, mipsPkg::SB: begin
				ctl.memWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.memByte = (op == mipsPkg::SB);
			end
			mipsPkg::BEQ, mipsPkg::BNE: ctl.branch = 1'b1;
			mipsPkg::J: ctl.jump = 1'b1;
			mipsPkg::JAL: begin
				ctl.jump = 1'b1;
				ctl.link = 1'b1;
				ctl.regWrite = 1'b1;
				dstSel = DST_RA;
			end
			mipsPkg::MFC0: begin
				ctl.regWrite = 1'b1;
				dstSel = DST_RT;
			end
			mipsPkg::MTC0: ctl.cp0Write = 1'b1;
			// hi/lo writers, traps and eret need no bits here
			default: ctl = '0;
		endcase
	end

	// source numbers straight from the word
	assign srcRegA = rs;
	assign srcRegB = rt;

	always_comb begin
		case (dstSel)
			DST_RD: destReg = rd;
			DST_RT: destReg = rt;
			DST_RA: destReg = mipsPkg::RA_REG;
			default: destReg = '0;
		endcase
	end

	assign reserved = (op == mipsPkg::RESERVED);

endmodule

`default_nettype wire

// File: hw/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// basic field widths
	localparam int WORD_W = 32;
	localparam int REG_W = 5;
	localparam int JR_TOP_W = 5;

	typedef logic [WORD_W-1:0] wordT;
	typedef logic [15:0] halfwordT;
	typedef logic [REG_W-1:0] cregAddrT;
	typedef logic [5:0] opFieldT;
	typedef logic [5:0] funcFieldT;
	typedef logic [4:0] shamtT;
	// return stack pointer hint from fetch
	typedef logic [JR_TOP_W-1:0] jrTopT;

	// link register written by jal
	localparam cregAddrT RA_REG = 5'd31;

	// primary opcodes
	localparam opFieldT OP_SPECIAL = 6'b000000;
	localparam opFieldT OP_J = 6'b000010;
	localparam opFieldT OP_JAL = 6'b000011;
	localparam opFieldT OP_BEQ = 6'b000100;
	localparam opFieldT OP_BNE = 6'b000101;
	localparam opFieldT OP_ADDIU = 6'b001001;
	localparam opFieldT OP_SLTI = 6'b001010;
	localparam opFieldT OP_SLTIU = 6'b001011;
	localparam opFieldT OP_ANDI = 6'b001100;
	localparam opFieldT OP_ORI = 6'b001101;
	localparam opFieldT OP_XORI = 6'b001110;
	localparam opFieldT OP_LUI = 6'b001111;
	localparam opFieldT OP_COP0 = 6'b010000;
	localparam opFieldT OP_LB = 6'b100000;
	localparam opFieldT OP_LW = 6'b100011;
	localparam opFieldT OP_LBU = 6'b100100;
	localparam opFieldT OP_SB = 6'b101000;
	localparam opFieldT OP_SW = 6'b101011;

	// function field under SPECIAL
	localparam funcFieldT FN_SLL = 6'b000000;
	localparam funcFieldT FN_SRL = 6'b000010;
	localparam funcFieldT FN_SRA = 6'b000011;
	localparam funcFieldT FN_JR = 6'b001000;
	localparam funcFieldT FN_JALR = 6'b001001;
	localparam funcFieldT FN_SYSCALL = 6'b001100;
	localparam funcFieldT FN_BREAK = 6'b001101;
	localparam funcFieldT FN_MFHI = 6'b010000;
	localparam funcFieldT FN_MTHI = 6'b010001;
	localparam funcFieldT FN_MFLO = 6'b010010;
	localparam funcFieldT FN_MTLO = 6'b010011;
	localparam funcFieldT FN_MULT = 6'b011000;
	localparam funcFieldT FN_MULTU = 6'b011001;
	localparam funcFieldT FN_DIV = 6'b011010;
	localparam funcFieldT FN_DIVU = 6'b011011;
	localparam funcFieldT FN_ADDU = 6'b100001;
	localparam funcFieldT FN_SUBU = 6'b100011;
	localparam funcFieldT FN_AND = 6'b100100;
	localparam funcFieldT FN_OR = 6'b100101;
	localparam funcFieldT FN_XOR = 6'b100110;
	localparam funcFieldT FN_NOR = 6'b100111;
	localparam funcFieldT FN_SLT = 6'b101010;
	localparam funcFieldT FN_SLTU = 6'b101011;

	// cop0 sub-ops in the rs field, eret in function under CO
	localparam cregAddrT RS_MF = 5'b00000;
	localparam cregAddrT RS_MT = 5'b00100;
	localparam cregAddrT RS_CO = 5'b10000;
	localparam funcFieldT FN_ERET = 6'b011000;

	// RESERVED sits at zero so a cleared bundle decodes as nothing
	typedef enum logic [5:0] {
		RESERVED = 6'd0,
		ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
		SLL, SRL, SRA, JR, JALR,
		MFHI, MFLO, MTHI, MTLO, MULT, MULTU, DIV, DIVU,
		SYSCALL, BREAK,
		ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
		LW, LB, LBU, SW, SB, BEQ, BNE,
		J, JAL, MFC0, MTC0, ERET
	} decodedOpT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memByte;
		logic memUnsigned;
		logic aluSrcImm;
		logic zeroExt;
		logic branch;
		logic jump;
		logic jumpReg;
		logic link;
		logic cp0Write;
	} controlT;

	// what fetch hands over, 71 bits
	typedef struct packed {
		wordT instr;
		wordT pcPlus4;
		logic pred;
		logic excInstr;
		jrTopT jrTop;
	} fetchDataT;

	typedef struct packed {
		decodedOpT op;
		controlT ctl;
		cregAddrT srcRegA;
		cregAddrT srcRegB;
		cregAddrT destReg;
		shamtT shamt;
		cregAddrT cp0Addr;
		wordT extImm;
		wordT pcBranch;
		wordT pcJump;
		logic excReserved;
		logic excInstr;
		logic pred;
		wordT pcPlus4;
		jrTopT jrTop;
	} decodeDataT;

endpackage

`default_nettype wire

// File: hw/pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input logic bubble,
	input logic validIn,
	input payloadT dataIn,
	output logic validOut,
	output payloadT dataOut
);

	// flush first, then bubble, then hold, then load
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validOut <= 1'b0;
			dataOut <= '0;
		end else if (flush || bubble) begin
			// empty slot with payload zeroed so control bits stay quiet
			validOut <= 1'b0;
			dataOut <= '0;
		end else if (!stall) begin
			validOut <= validIn;
			// an invalid input loads as an empty slot too
			if (validIn)
				dataOut <= dataIn;
			else
				dataOut <= '0;
		end
		// stall alone keeps the current contents
	end

endmodule

`default_nettype wire

// File: hw/signalDecode.sv
`timescale 1ns/1ps
`default_nettype none

module signalDecode (
	input mipsPkg::fetchDataT dataF,
	output mipsPkg::decodeDataT dataD
);

	mipsPkg::halfwordT imm;
	mipsPkg::cregAddrT rd;
	mipsPkg::shamtT shamt;
	mipsPkg::decodedOpT op;
	mipsPkg::controlT ctl;
	mipsPkg::cregAddrT srcRegA;
	mipsPkg::cregAddrT srcRegB;
	mipsPkg::cregAddrT destReg;
	logic isReserved;
	mipsPkg::wordT extImm;
	mipsPkg::wordT pcBranch;
	mipsPkg::wordT pcJump;

	// fields not handled by the main decoder
	assign imm = dataF.instr[15:0];
	assign rd = dataF.instr[15:11];
	assign shamt = dataF.instr[10:6];

	mainDecode mainDecode (
		.instr(dataF.instr),
		.op(op),
		.ctl(ctl),
		.srcRegA(srcRegA),
		.srcRegB(srcRegB),
		.destReg(destReg),
		.reserved(isReserved)
	);

	// zero ext for logical imm and lui, sign ext otherwise
	assign extImm = ctl.zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	// branch target wraps at 2^32
	assign pcBranch = dataF.pcPlus4 + {extImm[29:0], 2'b00};
	// jump target keeps the current 256MB region
	assign pcJump = {dataF.pcPlus4[31:28], dataF.instr[25:0], 2'b00};

	// assemble the bundle towards execute
	always_comb begin
		dataD.op = op;
		dataD.ctl = ctl;
		dataD.srcRegA = srcRegA;
		dataD.srcRegB = srcRegB;
		dataD.destReg = destReg;
		dataD.shamt = shamt;
		// cp0 register number sits in rd
		dataD.cp0Addr = rd;
		dataD.extImm = extImm;
		dataD.pcBranch = pcBranch;
		dataD.pcJump = pcJump;
		dataD.excReserved = isReserved;
		// side info from fetch, untouched
		dataD.excInstr = dataF.excInstr;
		dataD.pred = dataF.pred;
		dataD.pcPlus4 = dataF.pcPlus4;
		dataD.jrTop = dataF.jrTop;
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module decodeStageTb -f verilog.f -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

// File: tb/decodeStageProps.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageProps (
	input logic clk,
	input logic rstN,
	input logic validE,
	input mipsPkg::controlT ctlE,
	input logic excReservedE,
	input mipsPkg::cregAddrT destRegE
);

	// an empty execute slot drives no control
	idleQuiet: assert property (@(posedge clk) disable iff (!rstN)
		!validE |-> (ctlE == '0))
		else $error("control bits active while validE is low");

	// reserved words decode to nothing
	reservedQuiet: assert property (@(posedge clk) disable iff (!rstN)
		excReservedE |-> (ctlE == '0))
		else $error("control bits active on a reserved instruction");

	// no write, no destination
	destZero: assert property (@(posedge clk) disable iff (!rstN)
		!ctlE.regWrite |-> (destRegE == '0))
		else $error("destination register set without regWrite");

	// first edge after release only fills the F/D register
	resetBubble: assert property (@(posedge clk) $rose(rstN) |=> !validE)
		else $error("validE high right after reset release");

endmodule

`default_nettype wire

// File: tb/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// reference decode straight from the MIPS32 encoding tables
function automatic mipsPkg::decodedOpT refOp(input logic [31:0] w);
	mipsPkg::decodedOpT op;
	op = mipsPkg::RESERVED;
	case (w[31:26])
		6'h00: begin
			case (w[5:0])
				6'h00: op = mipsPkg::SLL;
				6'h02: op = mipsPkg::SRL;
				6'h03: op = mipsPkg::SRA;
				6'h08: op = mipsPkg::JR;
				6'h09: op = mipsPkg::JALR;
				6'h0c: op = mipsPkg::SYSCALL;
				6'h0d: op = mipsPkg::BREAK;
				6'h10: op = mipsPkg::MFHI;
				6'h11: op = mipsPkg::MTHI;
				6'h12: op = mipsPkg::MFLO;
				6'h13: op = mipsPkg::MTLO;
				6'h18: op = mipsPkg::MULT;
				6'h19: op = mipsPkg::MULTU;
				6'h1a: op = mipsPkg::DIV;
				6'h1b: op = mipsPkg::DIVU;
				6'h21: op = mipsPkg::ADDU;
				6'h23: op = mipsPkg::SUBU;
				6'h24: op = mipsPkg::AND;
				6'h25: op = mipsPkg::OR;
				6'h26: op = mipsPkg::XOR;
				6'h27: op = mipsPkg::NOR;
				6'h2a: op = mipsPkg::SLT;
				6'h2b: op = mipsPkg::SLTU;
				default: op = mipsPkg::RESERVED;
			endcase
		end
		6'h02: op = mipsPkg::J;
		6'h03: op = mipsPkg::JAL;
		6'h04: op = mipsPkg::BEQ;
		6'h05: op = mipsPkg::BNE;
		6'h09: op = mipsPkg::ADDIU;
		6'h0a: op = mipsPkg::SLTI;
		6'h0b: op = mipsPkg::SLTIU;
		6'h0c: op = mipsPkg::ANDI;
		6'h0d: op = mipsPkg::ORI;
		6'h0e: op = mipsPkg::XORI;
		6'h0f: op = mipsPkg::LUI;
		// cop0 sub-op in rs
		6'h10: begin
			if (w[25:21] == 5'h00)
				op = mipsPkg::MFC0;
			else if (w[25:21] == 5'h04)
				op = mipsPkg::MTC0;
			else if (w[25:21] == 5'h10 && w[5:0] == 6'h18)
				op = mipsPkg::ERET;
		end
		6'h20: op = mipsPkg::LB;
		6'h23: op = mipsPkg::LW;
		6'h24: op = mipsPkg::LBU;
		6'h28: op = mipsPkg::SB;
		6'h2b: op = mipsPkg::SW;
		default: op = mipsPkg::RESERVED;
	endcase
	return op;
endfunction

function automatic mipsPkg::controlT refCtl(input mipsPkg::decodedOpT op);
	mipsPkg::controlT c;
	c = '0;
	case (op)
		mipsPkg::ADDU, mipsPkg::SUBU, mipsPkg::AND, mipsPkg::OR, mipsPkg::XOR,
		mipsPkg::NOR, mipsPkg::SLT, mipsPkg::SLTU, mipsPkg::SLL, mipsPkg::SRL,
		mipsPkg::SRA, mipsPkg::MFHI, mipsPkg::MFLO, mipsPkg::MFC0:
			c.regWrite = 1'b1;
		mipsPkg::ADDIU, mipsPkg::SLTI, mipsPkg::SLTIU: begin
			c.regWrite = 1'b1;
			c.aluSrcImm = 1'b1;
		end
		mipsPkg::ANDI, mipsPkg::ORI, mipsPkg::XORI, mipsPkg::LUI: begin
			c.regWrite = 1'b1;
			c.aluSrcImm = 1'b1;
			c.zeroExt = 1'b1;
		end
		// word load
		mipsPkg::LW: begin
			c.regWrite = 1'b1;
			c.memRead = 1'b1;
			c.aluSrcImm = 1'b1;
		end
		// signed byte load
		mipsPkg::LB: begin
			c.regWrite = 1'b1;
			c.memRead = 1'b1;
			c.aluSrcImm = 1'b1;
			c.memByte = 1'b1;
		end
		mipsPkg::LBU: begin
			c.regWrite = 1'b1;
			c.memRead = 1'b1;
			c.aluSrcImm = 1'b1;
			c.memByte = 1'b1;
			c.memUnsigned = 1'b1;
		end
		mipsPkg::SW: begin
			c.memWrite = 1'b1;
			c.aluSrcImm = 1'b1;
		end
		mipsPkg::SB: begin
			c.memWrite = 1'b1;
			c.aluSrcImm = 1'b1;
			c.memByte = 1'b1;
		end
		mipsPkg::BEQ, mipsPkg::BNE:
			c.branch = 1'b1;
		mipsPkg::J:
			c.jump = 1'b1;
		mipsPkg::JAL: begin
			c.jump = 1'b1;
			c.link = 1'b1;
			c.regWrite = 1'b1;
		end
		mipsPkg::JR: begin
			c.jump = 1'b1;
			c.jumpReg = 1'b1;
		end
		mipsPkg::JALR: begin
			c.jump = 1'b1;
			c.jumpReg = 1'b1;
			c.link = 1'b1;
			c.regWrite = 1'b1;
		end
		mipsPkg::MTC0:
			c.cp0Write = 1'b1;
		default:
			c = '0;
	endcase
	return c;
endfunction

// rd for R-type, 31 for jal, rt otherwise, 0 with no write
function automatic logic [4:0] refDest(input mipsPkg::decodedOpT op,
		input mipsPkg::controlT c, input logic [31:0] w);
	logic [4:0] r;
	if (!c.regWrite)
		r = 5'd0;
	else if (op == mipsPkg::JAL)
		r = 5'd31;
	else if (w[31:26] == 6'h00)
		r = w[15:11];
	else
		r = w[20:16];
	return r;
endfunction

// full expected bundle for one accepted fetch word
function automatic mipsPkg::decodeDataT refBundle(input logic [31:0] w,
		input logic [31:0] pc4, input logic pred, input logic excInstr,
		input logic [4:0] jrTop);
	mipsPkg::decodeDataT d;
	logic [31:0] ext;
	logic zeroFill;
	d.op = refOp(w);
	d.ctl = refCtl(d.op);
	d.srcRegA = w[25:21];
	d.srcRegB = w[20:16];
	d.destReg = refDest(d.op, d.ctl, w);
	d.shamt = w[10:6];
	d.cp0Addr = w[15:11];
	// andi, ori, xori and lui take the immediate unsigned
	zeroFill = (d.op == mipsPkg::ANDI) || (d.op == mipsPkg::ORI)
		|| (d.op == mipsPkg::XORI) || (d.op == mipsPkg::LUI);
	ext = 32'(w[15:0]);
	if (!zeroFill && w[15])
		ext = ext | 32'hffff_0000;
	d.extImm = ext;
	// word offset wraps at 2^32
	d.pcBranch = pc4 + (ext << 2);
	d.pcJump = (pc4 & 32'hf000_0000) | (32'(w[25:0]) << 2);
	d.excReserved = (d.op == mipsPkg::RESERVED);
	d.excInstr = excInstr;
	d.pred = pred;
	d.pcPlus4 = pc4;
	d.jrTop = jrTop;
	return d;
endfunction

`endif

// File: tb/decodeStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;

	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 4;
	localparam int N_FIELDS = 2000;
	localparam int N_SWEEP = 42 * 20;
	localparam int N_RESERVED = 400;
	localparam int N_STALL = 2000;
	localparam int N_PASS = 500;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 4 + N_FIELDS + N_SWEEP + N_RESERVED
		+ N_STALL + N_PASS + 5 * DRAIN_CYCLES;

	// instruction sources per phase
	localparam int MODE_SUPPORTED = 0;
	localparam int MODE_SWEEP = 1;
	localparam int MODE_RESERVED = 2;
	localparam int MODE_MIX = 3;

	// function codes of the 23 SPECIAL ops
	localparam logic [5:0] FUNCT_CODES [0:22] = '{
		6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b,
		6'h00, 6'h02, 6'h03, 6'h08, 6'h09, 6'h10, 6'h12, 6'h11,
		6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h0c, 6'h0d
	};
	// I-type and J-type primary opcodes
	localparam logic [5:0] OPCODES [0:15] = '{
		6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23,
		6'h20, 6'h24, 6'h2b, 6'h28, 6'h04, 6'h05, 6'h02, 6'h03
	};

	typedef struct packed {
		mipsPkg::decodeDataT d;
		int acceptEdge;
		int stallMark;
	} expEntryT;

	logic clk = 1'b0;
	logic rstN;
	logic validF;
	logic [31:0] instrF;
	logic [31:0] pcPlus4F;
	logic predF;
	logic excInstrF;
	logic [4:0] jrTopF;
	logic stall;
	logic flush;
	logic validE;
	mipsPkg::decodedOpT opE;
	mipsPkg::controlT ctlE;
	mipsPkg::cregAddrT srcRegAE;
	mipsPkg::cregAddrT srcRegBE;
	mipsPkg::cregAddrT destRegE;
	mipsPkg::shamtT shamtE;
	mipsPkg::cregAddrT cp0AddrE;
	mipsPkg::wordT extImmE;
	mipsPkg::wordT pcBranchE;
	mipsPkg::wordT pcJumpE;
	logic excReservedE;
	logic excInstrE;
	logic predE;
	mipsPkg::wordT pcPlus4E;
	mipsPkg::jrTopT jrTopE;

	// accepted and not yet seen at the output
	expEntryT expQ[$];
	int edgeNum = 0;
	int stallEdges = 0;
	int flushedCount = 0;
	int curTest = 0;
	int checks [0:5];
	int errs [0:5];

	`include "decodeModel.svh"

	always #2 clk = ~clk;

	decodeStage dut_i (
		.clk(clk),
		.rstN(rstN),
		.validF(validF),
		.instrF(instrF),
		.pcPlus4F(pcPlus4F),
		.predF(predF),
		.excInstrF(excInstrF),
		.jrTopF(jrTopF),
		.stall(stall),
		.flush(flush),
		.validE(validE),
		.opE(opE),
		.ctlE(ctlE),
		.srcRegAE(srcRegAE),
		.srcRegBE(srcRegBE),
		.destRegE(destRegE),
		.shamtE(shamtE),
		.cp0AddrE(cp0AddrE),
		.extImmE(extImmE),
		.pcBranchE(pcBranchE),
		.pcJumpE(pcJumpE),
		.excReservedE(excReservedE),
		.excInstrE(excInstrE),
		.predE(predE),
		.pcPlus4E(pcPlus4E),
		.jrTopE(jrTopE)
	);

	bind decodeStage decodeStageProps props_i (
		.clk(clk),
		.rstN(rstN),
		.validE(validE),
		.ctlE(ctlE),
		.excReservedE(excReservedE),
		.destRegE(destRegE)
	);

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks[curTest]++;
		if (got !== exp) begin
			errs[curTest]++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// idx 0..22 SPECIAL, 23..38 I/J-type, 39..41 cop0
	function automatic logic [31:0] buildSupported(input int idx);
		logic [31:0] w;
		w = $urandom;
		if (idx < 23) begin
			w[31:26] = 6'h00;
			w[5:0] = FUNCT_CODES[idx];
		end else if (idx < 39) begin
			w[31:26] = OPCODES[idx-23];
		end else begin
			w[31:26] = 6'h10;
			case (idx)
				39: w[25:21] = 5'h00;
				40: w[25:21] = 5'h04;
				default: begin
					w[25:21] = 5'h10;
					w[5:0] = 6'h18;
				end
			endcase
		end
		return w;
	endfunction

	function automatic logic [31:0] pickInstr(input int mode, input int i);
		logic [31:0] w;
		int tries;
		tries = 0;
		case (mode)
			MODE_SUPPORTED: w = buildSupported(int'($urandom_range(41, 0)));
			MODE_SWEEP: w = buildSupported(i % 42);
			MODE_RESERVED: begin
				// redraw until the word falls outside the subset
				w = $urandom;
				while (refOp(w) != mipsPkg::RESERVED && tries < 100) begin
					w = $urandom;
					tries++;
				end
			end
			default: begin
				if ($urandom_range(99, 0) < 70)
					w = buildSupported(int'($urandom_range(41, 0)));
				else
					w = $urandom;
			end
		endcase
		return w;
	endfunction

	task automatic checkOutputs();
		expEntryT e;
		if (validE && expQ.size() == 0) begin
			errs[curTest]++;
			$display("Error at %0t: validE is high but no instruction is expected", $time);
		end else if (validE) begin
			e = expQ.pop_front();
			checkValue("opE", 32'(opE), 32'(e.d.op));
			checkValue("ctlE", 32'(ctlE), 32'(e.d.ctl));
			checkValue("srcRegAE", 32'(srcRegAE), 32'(e.d.srcRegA));
			checkValue("srcRegBE", 32'(srcRegBE), 32'(e.d.srcRegB));
			checkValue("destRegE", 32'(destRegE), 32'(e.d.destReg));
			checkValue("shamtE", 32'(shamtE), 32'(e.d.shamt));
			checkValue("cp0AddrE", 32'(cp0AddrE), 32'(e.d.cp0Addr));
			checkValue("extImmE", extImmE, e.d.extImm);
			checkValue("pcBranchE", pcBranchE, e.d.pcBranch);
			checkValue("pcJumpE", pcJumpE, e.d.pcJump);
			checkValue("excReservedE", 32'(excReservedE), 32'(e.d.excReserved));
			checkValue("excInstrE", 32'(excInstrE), 32'(e.d.excInstr));
			checkValue("predE", 32'(predE), 32'(e.d.pred));
			checkValue("pcPlus4E", pcPlus4E, e.d.pcPlus4);
			checkValue("jrTopE", 32'(jrTopE), 32'(e.d.jrTop));
			// one edge past capture, plus one per stalled edge
			checkValue("edgesToOutput", 32'(edgeNum - e.acceptEdge),
				32'(1 + stallEdges - e.stallMark));
		end
	endtask

	// bookkeeping for the inputs seen at this edge
	task automatic trackEdge();
		expEntryT e;
		edgeNum++;
		if (flush) begin
			flushedCount += expQ.size();
			expQ.delete();
		end else if (stall) begin
			stallEdges++;
		end else if (validF) begin
			e.d = refBundle(instrF, pcPlus4F, predF, excInstrF, jrTopF);
			e.acceptEdge = edgeNum;
			e.stallMark = stallEdges;
			expQ.push_back(e);
		end
	endtask

	// called 1 ns after an edge, returns 1 ns after the next
	task automatic finishCycle();
		@(negedge clk);
		if (rstN)
			checkOutputs();
		@(posedge clk);
		if (rstN)
			trackEdge();
		#1;
	endtask

	task automatic runPhase(input int n, input int mode, input int stallPct,
			input int flushPct);
		logic held;
		int i;
		held = 1'b0;
		for (i = 0; i < n; i++) begin
			// fetch keeps its word while stalled
			if (!held) begin
				validF = (mode != MODE_MIX) || ($urandom_range(99, 0) < 85);
				instrF = pickInstr(mode, i);
				pcPlus4F = $urandom;
				predF = 1'($urandom);
				excInstrF = 1'($urandom);
				jrTopF = 5'($urandom);
			end
			stall = ($urandom_range(99, 0) < stallPct);
			flush = ($urandom_range(99, 0) < flushPct);
			held = stall;
			finishCycle();
		end
		validF = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		repeat (DRAIN_CYCLES) finishCycle();
		if (expQ.size() != 0) begin
			errs[curTest]++;
			$display("Error: %0d accepted instructions never reached the output",
				expQ.size());
			expQ.delete();
		end
	endtask

	task automatic reportTest(input string title);
		$display("test %0d %s: %0d checks, %0d errors", curTest + 1, title,
			checks[curTest], errs[curTest]);
	endtask

	initial begin
		int i;
		int totalChecks;
		int totalErrors;
		rstN = 1'b0;
		validF = 1'b0;
		instrF = '0;
		pcPlus4F = '0;
		predF = 1'b0;
		excInstrF = 1'b0;
		jrTopF = '0;
		stall = 1'b0;
		flush = 1'b0;
		for (i = 0; i < 6; i++) begin
			checks[i] = 0;
			errs[i] = 0;
		end
		void'($urandom(92));

		// outputs quiet in reset and just after
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			checkValue("validE", 32'(validE), 32'd0);
			checkValue("ctlE", 32'(ctlE), 32'd0);
		end
		@(posedge clk);
		#1;
		rstN = 1'b1;
		for (i = 0; i < 3; i++) begin
			@(negedge clk);
			checkValue("validE", 32'(validE), 32'd0);
			checkValue("ctlE", 32'(ctlE), 32'd0);
			@(posedge clk);
			#1;
		end
		reportTest("reset state");

		curTest = 1;
		runPhase(N_FIELDS, MODE_SUPPORTED, 0, 0);
		reportTest("fields and targets");
		curTest = 2;
		runPhase(N_SWEEP, MODE_SWEEP, 0, 0);
		reportTest("operation, control and registers");
		curTest = 3;
		runPhase(N_RESERVED, MODE_RESERVED, 0, 0);
		reportTest("reserved encodings");
		curTest = 4;
		runPhase(N_STALL, MODE_MIX, 15, 3);
		reportTest("stall and flush");
		curTest = 5;
		runPhase(N_PASS, MODE_MIX, 15, 0);
		reportTest("pass-through");

		totalChecks = 0;
		totalErrors = 0;
		for (i = 0; i < 6; i++) begin
			totalChecks += checks[i];
			totalErrors += errs[i];
		end
		$display("summary: 6 tests, %0d checks, %0d errors, %0d flushed", totalChecks,
			totalErrors, flushedCount);
		if (totalErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// three times the nominal run length
	initial begin
		#(TOTAL_CYCLES * 4 * 3);
		$display("Error: run did not finish within %0d ns", TOTAL_CYCLES * 4 * 3);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tb
hw/mipsPkg.sv
hw/pipeReg.sv
hw/mainDecode.sv
hw/signalDecode.sv
hw/decodeStage.sv
tb/decodeStageProps.sv
tb/decodeStageTb.sv
